// File: rtl/elk_macros.svh
// memory map and cassette constants
// bank geometry, page codes, adc window and hysteresis
`ifndef ELK_MACROS_SVH
`define ELK_MACROS_SVH

// cpu bus and bank geometry
`define ELK_BUS_AW          19
`define ELK_BANK_AW         14
`define ELK_ROM_BANKS       7
`define ELK_RAM_BANKS       8
`define ELK_ROM_LOAD_INDEX  8'd0

// page codes on bus bits 18..14, prefixes of varying length
`define ELK_PG_ROM0   5'b0_01_00
`define ELK_PG_OS     4'b0_10_0
`define ELK_PG_BASIC  4'b0_10_1
`define ELK_PG_ROMHI  3'b0_11
`define ELK_PG_RAM    2'b1_0

// cassette adc
`define ELK_ADC_W     12
`define ELK_WIN_LOG2  9
`define ELK_HYST      100

`endif

// File: rtl/elk_mem_pkg.sv
// memory map types
// bus address, data byte, bank offset and select
// bus request, loader write and decoded page structs
`include "elk_macros.svh"

package elk_mem_pkg;

	typedef logic [`ELK_BUS_AW-1:0]  bus_addr_t;
	typedef logic [7:0]              byte_t;
	typedef logic [`ELK_BANK_AW-1:0] bank_off_t;
	typedef logic [2:0]              bank_sel_t;
	// bank number over offset
	typedef logic [`ELK_BANK_AW+2:0] store_addr_t;

	// cpu side of the external bus
	typedef struct packed {
		bus_addr_t addr;
		byte_t     wdata;
		logic      we_n;
	} bus_req_t;

	// download port, one byte per wr pulse
	typedef struct packed {
		logic [7:0]  index;
		store_addr_t addr;
		byte_t       data;
		logic        wr;
	} load_wr_t;

	// at most one hit flag set
	typedef struct packed {
		logic      rom_hit;
		logic      ram_hit;
		bank_sel_t bank;
		bank_off_t off;
	} page_dec_t;

endpackage

// File: rtl/elk_tape_pkg.sv
// cassette types
// adc sample, window sum and the adc input struct
`include "elk_macros.svh"

package elk_tape_pkg;

	typedef logic [`ELK_ADC_W-1:0] adc_sample_t;

	// wide enough for a full window of max samples
	typedef logic [`ELK_ADC_W+`ELK_WIN_LOG2-1:0] win_sum_t;

	// new sample is flagged by a toggle of sync
	typedef struct packed {
		adc_sample_t sample;
		logic        sync;
	} adc_in_t;

endpackage

// File: rtl/elk_page_decode.sv
// bus page decoder
// maps bus bits 18..14 onto rom or sideways ram bank numbers
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_page_decode (
	input  elk_mem_pkg::bus_req_t  i_bus,
	output elk_mem_pkg::page_dec_t o_page
);

	////////////////////////////////////////////////////////////
	// page field
	////////////////////////////////////////////////////////////

	// 16k page number, 5 bits
	logic [4:0] page;

	assign page = i_bus.addr[`ELK_BUS_AW-1:`ELK_BANK_AW];

	////////////////////////////////////////////////////////////
	// page tables
	////////////////////////////////////////////////////////////

	always_comb begin
		// offset always passes straight through
		o_page.off     = i_bus.addr[`ELK_BANK_AW-1:0];
		o_page.rom_hit = 1'b0;
		o_page.ram_hit = 1'b0;
		o_page.bank    = '0;

		if (page == `ELK_PG_ROM0) begin
			// single page rom slot
			o_page.rom_hit = 1'b1;
			o_page.bank    = 3'd0;
		end else if (page[4:1] == `ELK_PG_OS) begin
			// os rom, mirrored over two pages
			o_page.rom_hit = 1'b1;
			o_page.bank    = 3'd1;
		end else if (page[4:1] == `ELK_PG_BASIC) begin
			// basic rom, also mirrored
			o_page.rom_hit = 1'b1;
			o_page.bank    = 3'd2;
		end else if (page[4:2] == `ELK_PG_ROMHI) begin
			// four upper rom slots, banks 3..6
			o_page.rom_hit = 1'b1;
			o_page.bank    = 3'd3 + {1'b0, page[1:0]};
		end else if (page[4:3] == `ELK_PG_RAM) begin
			// eight sideways ram pages in order
			o_page.ram_hit = 1'b1;
			o_page.bank    = page[2:0];
		end
		// anything else left unmapped
	end

endmodule

// File: rtl/elk_bank_store.sv
// rom and sideways ram storage
// loader port into rom during reset, falling edge ram write
// registered read with hit select and zero fill
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_bank_store (
	input  logic                   clk_sys,
	input  logic                   i_reset,
	input  elk_mem_pkg::page_dec_t i_page,
	input  elk_mem_pkg::byte_t     i_wdata,
	input  logic                   i_we_n,
	input  elk_mem_pkg::load_wr_t  i_load,
	output elk_mem_pkg::byte_t     o_rdata
);

	localparam int ROM_DEPTH = `ELK_ROM_BANKS << `ELK_BANK_AW;
	localparam int RAM_DEPTH = `ELK_RAM_BANKS << `ELK_BANK_AW;

	elk_mem_pkg::byte_t rom_mem [0:ROM_DEPTH-1];
	elk_mem_pkg::byte_t ram_mem [0:RAM_DEPTH-1];

	elk_mem_pkg::store_addr_t bus_addr;
	elk_mem_pkg::store_addr_t rom_addr;
	elk_mem_pkg::byte_t       rom_q;
	elk_mem_pkg::byte_t       ram_q;

	logic we_n_q;
	logic rom_we;
	logic ram_we;
	logic rom_hit_q;
	logic ram_hit_q;

	////////////////////////////////////////////////////////////
	// address and write enables
	////////////////////////////////////////////////////////////

	assign bus_addr = {i_page.bank, i_page.off};

	// loader owns the rom address while reset is held
	assign rom_addr = i_reset ? i_load.addr : bus_addr;
	assign rom_we   = i_reset & i_load.wr & (i_load.index == `ELK_ROM_LOAD_INDEX);

	// one write per high to low step of the strobe
	assign ram_we = i_page.ram_hit & we_n_q & ~i_we_n;

	// previous strobe level
	// held at zero in reset, so a strobe low at release is no edge
	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			we_n_q <= 1'b0;
		end else begin
			we_n_q <= i_we_n;
		end
	end

	////////////////////////////////////////////////////////////
	// arrays
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rom_we) begin
			rom_mem[rom_addr] <= i_load.data;
		end
		rom_q <= rom_mem[rom_addr];
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram_mem[bus_addr] <= i_wdata;
		end
		ram_q <= ram_mem[bus_addr];
	end

	////////////////////////////////////////////////////////////
	// read select
	////////////////////////////////////////////////////////////

	// hit flags follow the array read by one cycle
	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			rom_hit_q <= 1'b0;
			ram_hit_q <= 1'b0;
		end else begin
			rom_hit_q <= i_page.rom_hit;
			ram_hit_q <= i_page.ram_hit;
		end
	end

	// unmapped page reads zero
	always_comb begin
		if (ram_hit_q) begin
			o_rdata = ram_q;
		end else if (rom_hit_q) begin
			o_rdata = rom_q;
		end else begin
			o_rdata = '0;
		end
	end

endmodule

// File: rtl/elk_cassette_slicer.sv
// cassette input slicer
// sync toggle detect, circular 512 sample window with running sum
// hysteresis compare of each sample against the window average
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_cassette_slicer (
	input  logic                  clk_sys,
	input  logic                  i_reset,
	input  elk_tape_pkg::adc_in_t i_adc,
	output logic                  o_tape_bit
);

	localparam int WIN_DEPTH = 1 << `ELK_WIN_LOG2;
	localparam logic [`ELK_ADC_W:0] HYST = `ELK_HYST;

	elk_tape_pkg::adc_sample_t win_mem [0:WIN_DEPTH-1];

	logic [`ELK_WIN_LOG2-1:0] wr_ptr;
	logic                     win_full;
	logic                     sync_q;
	logic                     new_smp;
	logic                     upd_q;

	elk_tape_pkg::adc_sample_t smp_q;
	elk_tape_pkg::adc_sample_t oldest_q;
	elk_tape_pkg::adc_sample_t avg;
	elk_tape_pkg::win_sum_t    sum_q;

	logic below;
	logic above;

	////////////////////////////////////////////////////////////
	// stage 1, sample capture
	////////////////////////////////////////////////////////////

	// any change of sync marks a fresh sample
	assign new_smp = i_adc.sync ^ sync_q;

	always_ff @(posedge clk_sys) begin
		sync_q <= i_adc.sync;
		if (new_smp) begin
			smp_q <= i_adc.sample;
			// entries not yet written count as zero
			oldest_q <= win_full ? win_mem[wr_ptr] : '0;
		end
	end

	// update strobe for stage 2
	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			upd_q <= 1'b0;
		end else begin
			upd_q <= new_smp;
		end
	end

	////////////////////////////////////////////////////////////
	// stage 2, window update and slice
	////////////////////////////////////////////////////////////

	// average over the 512 samples before this one
	assign avg = sum_q[`ELK_ADC_W+`ELK_WIN_LOG2-1:`ELK_WIN_LOG2];

	// one extra bit so the offsets never wrap
	assign below = ({1'b0, smp_q} + HYST) < {1'b0, avg};
	assign above = {1'b0, smp_q} > ({1'b0, avg} + HYST);

	always_ff @(posedge clk_sys) begin
		if (upd_q) begin
			win_mem[wr_ptr] <= smp_q;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (i_reset) begin
			wr_ptr     <= '0;
			win_full   <= 1'b0;
			sum_q      <= '0;
			o_tape_bit <= 1'b0;
		end else if (upd_q) begin
			// drop oldest, add newest
			sum_q  <= sum_q - oldest_q + smp_q;
			wr_ptr <= wr_ptr + 1'b1;
			if (&wr_ptr) begin
				win_full <= 1'b1;
			end
			// low level on tape reads as a one
			if (below) begin
				o_tape_bit <= 1'b1;
			end else if (above) begin
				o_tape_bit <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/elk_io_top.sv
// platform glue top level
// page decoder into bank storage, cassette slicer alongside
`timescale 1ns/1ps

module elk_io_top (
	input  logic                   clk_sys,
	input  logic                   i_reset,
	input  elk_mem_pkg::bus_req_t  i_bus,
	input  elk_mem_pkg::load_wr_t  i_load,
	input  elk_tape_pkg::adc_in_t  i_adc,
	output elk_mem_pkg::byte_t     o_rdata,
	output logic                   o_tape_bit
);

	// decoded page, combinational from the bus
	elk_mem_pkg::page_dec_t page;

	////////////////////////////////////////////////////////////
	// external memory map
	////////////////////////////////////////////////////////////

	elk_page_decode u_page_decode (
		.i_bus  (i_bus),
		.o_page (page)
	);

	elk_bank_store u_bank_store (
		.clk_sys (clk_sys),
		.i_reset (i_reset),
		.i_page  (page),
		.i_wdata (i_bus.wdata),
		.i_we_n  (i_bus.we_n),
		.i_load  (i_load),
		.o_rdata (o_rdata)
	);

	////////////////////////////////////////////////////////////
	// cassette input
	////////////////////////////////////////////////////////////

	elk_cassette_slicer u_cassette_slicer (
		.clk_sys    (clk_sys),
		.i_reset    (i_reset),
		.i_adc      (i_adc),
		.o_tape_bit (o_tape_bit)
	);

endmodule

// File: sim/elk_io_sva.sv
// checks on the memory arrays and the cassette output
// one checker, bound into the bank store and the slicer
`timescale 1ns/1ps

module elk_io_sva (
	input logic                     clk_sys,
	input logic                     i_reset,
	input logic                     ram_hit,
	input logic                     we_n,
	input elk_mem_pkg::store_addr_t bus_addr,
	input elk_mem_pkg::byte_t       ram_byte,
	input elk_mem_pkg::store_addr_t rom_addr,
	input elk_mem_pkg::byte_t       rom_byte,
	input logic                     tape_bit
);

	int unsigned assert_fails = 0;

	// ram byte under a steady address moves only after
	// a high to low strobe step on a ram page
	a_ram_we_edge: assert property (@(posedge clk_sys) disable iff (i_reset)
		(bus_addr === $past(bus_addr) && ram_byte !== $past(ram_byte))
		|-> ($past(ram_hit && !we_n) && $past(we_n, 2)))
	else begin
		$error("ram byte changed without a strobe falling edge on a ram page");
		assert_fails++;
	end

	// rom contents frozen once reset has gone
	a_rom_frozen: assert property (@(posedge clk_sys)
		(!i_reset && !$past(i_reset) && rom_addr === $past(rom_addr))
		|-> (rom_byte === $past(rom_byte)))
	else begin
		$error("rom byte changed while reset is low");
		assert_fails++;
	end

	a_tape_known: assert property (@(posedge clk_sys) disable iff (i_reset)
		!$isunknown(tape_bit))
	else begin
		$error("tape bit undefined after reset");
		assert_fails++;
	end

endmodule

// memory side, tape port tied off
bind elk_bank_store elk_io_sva mem_sva (
	.clk_sys  (clk_sys),
	.i_reset  (i_reset),
	.ram_hit  (i_page.ram_hit),
	.we_n     (i_we_n),
	.bus_addr (bus_addr),
	.ram_byte (ram_mem[bus_addr]),
	.rom_addr (rom_addr),
	.rom_byte (rom_mem[rom_addr]),
	.tape_bit (1'b0)
);

// tape side, memory ports idle
bind elk_cassette_slicer elk_io_sva tape_sva (
	.clk_sys  (clk_sys),
	.i_reset  (i_reset),
	.ram_hit  (1'b0),
	.we_n     (1'b1),
	.bus_addr ('0),
	.ram_byte ('0),
	.rom_addr ('0),
	.rom_byte ('0),
	.tape_bit (o_tape_bit)
);

// File: sim/elk_io_tb.sv
// testbench for the platform glue top level
// memory map tests driven from a hex data file
// lcg cassette samples checked against a window slicer model
`timescale 1ns/1ps
`include "elk_macros.svh"

module elk_io_tb;

	localparam int REC_WORDS = 4;
	localparam int MAX_RECS  = 64;
	localparam int N_SAMPLES = 1200;
	localparam int WIN_DEPTH = 1 << `ELK_WIN_LOG2;

	// record op codes
	localparam logic [31:0] OP_SECTION    = 32'h00;
	localparam logic [31:0] OP_ROM_LOAD   = 32'h01;
	localparam logic [31:0] OP_WRITE      = 32'h02;
	localparam logic [31:0] OP_READ       = 32'h03;
	localparam logic [31:0] OP_HOLD_WRITE = 32'h04;
	localparam logic [31:0] OP_END        = 32'hff;

	logic                  clk_sys;
	logic                  i_reset;
	elk_mem_pkg::bus_req_t i_bus;
	elk_mem_pkg::load_wr_t i_load;
	elk_tape_pkg::adc_in_t i_adc;
	elk_mem_pkg::byte_t    o_rdata;
	logic                  o_tape_bit;

	logic [31:0] tdata [0:REC_WORDS*MAX_RECS-1];

	int          err_count;
	int          check_count;
	int          sect_id;
	int          sect_errs;
	int          sect_checks;
	int          sva_fails;
	bit          timeout_hit;
	bit          in_load_reset;
	logic [31:0] lcg_state;
	string       sect_names [1:5];

	elk_io_top dut0 (
		.clk_sys    (clk_sys),
		.i_reset    (i_reset),
		.i_bus      (i_bus),
		.i_load     (i_load),
		.i_adc      (i_adc),
		.o_rdata    (o_rdata),
		.o_tape_bit (o_tape_bit)
	);

	// 100 ns period
	always #50 clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic step(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic check_byte(input string sig, input string where,
			input elk_mem_pkg::byte_t got, input elk_mem_pkg::byte_t exp);
		check_count++;
		sect_checks++;
		if (got !== exp) begin
			$display("** Error: %s = 0x%02h, expected 0x%02h (%s)", sig, got, exp, where);
			err_count++;
			sect_errs++;
		end
	endtask

	task automatic check_bit(input string sig, input string where,
			input logic got, input logic exp);
		check_count++;
		sect_checks++;
		if (got !== exp) begin
			$display("** Error: %s = 0x%01h, expected 0x%01h (%s)", sig, got, exp, where);
			err_count++;
			sect_errs++;
		end
	endtask

	// bounded wait for a defined tape bit once reset is gone
	task automatic wait_tape_known(input int limit);
		int n;
		n = 0;
		while ($isunknown(o_tape_bit) && n < limit) begin
			@(posedge clk_sys);
			n++;
		end
		if ($isunknown(o_tape_bit)) begin
			$display("timeout: tape bit still undefined %0d cycles after reset", limit);
			timeout_hit = 1'b1;
		end
	endtask

	task automatic end_section();
		if (sect_id >= 1 && sect_id <= 5) begin
			$display("test %0d %s: %0d checks, %0d errors",
				sect_id, sect_names[sect_id], sect_checks, sect_errs);
		end
		sect_checks = 0;
		sect_errs   = 0;
	endtask

	////////////////////////////////////////////////////////////
	// bus and loader drivers
	////////////////////////////////////////////////////////////

	task automatic rom_load(input logic [31:0] addr, input logic [7:0] data);
		@(posedge clk_sys);
		i_load.index <= `ELK_ROM_LOAD_INDEX;
		i_load.addr  <= addr[16:0];
		i_load.data  <= data;
		i_load.wr    <= 1'b1;
		@(posedge clk_sys);
		i_load.wr <= 1'b0;
	endtask

	// strobe goes low once, data keeps moving while it stays low
	task automatic bus_write(input logic [31:0] addr, input logic [7:0] data, input int hold);
		@(posedge clk_sys);
		i_bus.addr  <= addr[18:0];
		i_bus.wdata <= data;
		i_bus.we_n  <= 1'b1;
		@(posedge clk_sys);
		i_bus.we_n <= 1'b0;
		for (int k = 0; k < hold; k++) begin
			@(posedge clk_sys);
			i_bus.wdata <= data + 8'(k + 1);
		end
		@(posedge clk_sys);
		i_bus.we_n <= 1'b1;
	endtask

	// one cycle read latency
	task automatic bus_read(input logic [31:0] addr, input logic [7:0] exp);
		@(posedge clk_sys);
		i_bus.addr <= addr[18:0];
		i_bus.we_n <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_byte("o_rdata", $sformatf("read 0x%05h", addr[18:0]), o_rdata, exp);
	endtask

	task automatic release_reset();
		// loader reset runs well past the normal 8 cycles
		step(8);
		i_reset <= 1'b0;
		in_load_reset = 1'b0;
		wait_tape_known(16);
	endtask

	////////////////////////////////////////////////////////////
	// memory map tests
	////////////////////////////////////////////////////////////

	task automatic run_memory_tests();
		int          r;
		bit          done;
		logic [31:0] op;
		logic [31:0] addr;
		logic [7:0]  data;
		logic [7:0]  exp;
		r    = 0;
		done = 1'b0;
		while (!done && !timeout_hit && r < MAX_RECS) begin
			op   = tdata[r*REC_WORDS];
			addr = tdata[r*REC_WORDS+1];
			data = tdata[r*REC_WORDS+2][7:0];
			exp  = tdata[r*REC_WORDS+3][7:0];
			// rom loads only land while reset is held
			if (op == OP_ROM_LOAD && !in_load_reset) begin
				@(posedge clk_sys);
				i_reset <= 1'b1;
				in_load_reset = 1'b1;
				step(2);
			end else if (op != OP_ROM_LOAD && in_load_reset) begin
				release_reset();
			end
			case (op)
				OP_SECTION: begin
					end_section();
					sect_id = data;
				end
				OP_ROM_LOAD:   rom_load(addr, data);
				OP_WRITE:      bus_write(addr, data, 0);
				OP_HOLD_WRITE: bus_write(addr, data, 4);
				OP_READ:       bus_read(addr, exp);
				OP_END:        done = 1'b1;
				default: begin
					$display("unknown op 0x%0h in test data record %0d", op, r);
					err_count++;
					done = 1'b1;
				end
			endcase
			r++;
		end
		if (!done && !timeout_hit) begin
			$display("test data has no end record");
			err_count++;
		end
		end_section();
	endtask

	////////////////////////////////////////////////////////////
	// cassette slicer test
	////////////////////////////////////////////////////////////

	task automatic run_slicer_test();
		int   win [0:WIN_DEPTH-1];
		int   sum;
		int   ptr;
		int   avg;
		int   level;
		int   noise;
		int   s;
		logic model_bit;
		sect_id = 5;
		for (int i = 0; i < WIN_DEPTH; i++) begin
			win[i] = 0;
		end
		sum       = 0;
		ptr       = 0;
		model_bit = 1'b0;
		lcg_state = 32'h77c96140;
		for (int i = 0; i < N_SAMPLES; i++) begin
			lcg_state = lcg_next(lcg_state);
			// two level wave, 64 samples per level, noise of +-256
			level = ((i / 64) % 2 == 1) ? 3000 : 1000;
			noise = int'(lcg_state[31:23]) - 256;
			s     = level + noise;
			// average of the 512 samples before this one
			avg = sum / WIN_DEPTH;
			if (s + `ELK_HYST < avg) begin
				model_bit = 1'b1;
			end else if (s > avg + `ELK_HYST) begin
				model_bit = 1'b0;
			end
			sum      = sum - win[ptr] + s;
			win[ptr] = s;
			ptr      = (ptr + 1) % WIN_DEPTH;
			@(posedge clk_sys);
			i_adc.sample <= elk_tape_pkg::adc_sample_t'(s);
			i_adc.sync   <= ~i_adc.sync;
			step(4);
			@(negedge clk_sys);
			check_bit("o_tape_bit", $sformatf("sample %0d", i), o_tape_bit, model_bit);
			step(3);
		end
		end_section();
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		$readmemh("sim/elk_testdata.hex", tdata);
		clk_sys       = 1'b0;
		i_reset       = 1'b1;
		i_bus         = '0;
		i_bus.we_n    = 1'b1;
		i_load        = '0;
		i_adc         = '0;
		err_count     = 0;
		check_count   = 0;
		sect_id       = 0;
		sect_errs     = 0;
		sect_checks   = 0;
		timeout_hit   = 1'b0;
		in_load_reset = 1'b0;
		sect_names[1] = "rom load and read";
		sect_names[2] = "ram bank isolation";
		sect_names[3] = "single write per strobe edge";
		sect_names[4] = "unmapped and protected pages";
		sect_names[5] = "cassette slicer";

		step(8);
		i_reset <= 1'b0;
		wait_tape_known(16);
		if (!timeout_hit) begin
			run_memory_tests();
		end
		if (!timeout_hit) begin
			run_slicer_test();
		end

		sva_fails = dut0.u_bank_store.mem_sva.assert_fails
			+ dut0.u_cassette_slicer.tape_sva.assert_fails;
		$display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
			check_count, err_count, sva_fails, timeout_hit);
		if (err_count == 0 && sva_fails == 0 && !timeout_hit) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: sim/elk_testdata.hex
// columns: op addr data expected, all hex
// op 00 section (data = test number), 01 rom load, 02 write, 03 read, 04 held write, ff end
00 00000 01 00
01 00123 3c 00
01 04123 5a 00
01 08123 69 00
01 0c123 96 00
01 10123 c3 00
01 14123 e7 00
01 18123 18 00
03 10123 00 3c
03 20123 00 5a
03 24123 00 5a
03 28123 00 69
03 2c123 00 69
03 30123 00 96
03 34123 00 c3
03 38123 00 e7
03 3c123 00 18
00 00000 02 00
02 40456 11 00
02 44456 22 00
02 48456 33 00
02 4c456 44 00
02 50456 55 00
02 54456 66 00
02 58456 77 00
02 5c456 88 00
03 40456 00 11
03 44456 00 22
03 48456 00 33
03 4c456 00 44
03 50456 00 55
03 54456 00 66
03 58456 00 77
03 5c456 00 88
00 00000 03 00
04 4a000 5c 00
04 5c010 d2 00
03 4a000 00 5c
03 5c010 00 d2
00 00000 04 00
03 00123 00 00
03 14123 00 00
03 60456 00 00
02 10123 ff 00
02 60456 99 00
03 10123 00 3c
03 40456 00 11
ff 00000 00 00

// File: compile.f
+incdir+rtl
rtl/elk_mem_pkg.sv
rtl/elk_tape_pkg.sv
rtl/elk_page_decode.sv
rtl/elk_bank_store.sv
rtl/elk_cassette_slicer.sv
rtl/elk_io_top.sv
sim/elk_io_sva.sv
sim/elk_io_tb.sv
